// ==== verilog/exu_defs.svh ====
/*
 * width, credit and divider step macros for the execute stage.
 */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

`define EXU_XLEN 32

// memory-stage slots granted after reset.
`define EXU_CREDITS 4
`define EXU_CRED_W 3

`define EXU_DIV_STEPS 32

`endif

// ==== verilog/exu_pkg.sv ====
/*
 * operation codes, result select and control state types.
 */
`default_nettype none

package exu_pkg;

  // low three bits follow funct3, top two bits give the class.
  typedef enum logic [4:0] {
    alu_add    = 5'b00_000,
    alu_sll    = 5'b00_001,
    alu_slt    = 5'b00_010,
    alu_sltu   = 5'b00_011,
    alu_xor    = 5'b00_100,
    alu_srl    = 5'b00_101,
    alu_or     = 5'b00_110,
    alu_and    = 5'b00_111,
    alu_sub    = 5'b01_000,
    alu_sra    = 5'b01_101,
    alu_mul    = 5'b10_000,
    alu_mulh   = 5'b10_001,
    alu_mulhsu = 5'b10_010,
    alu_mulhu  = 5'b10_011,
    alu_div    = 5'b10_100,
    alu_divu   = 5'b10_101,
    alu_rem    = 5'b10_110,
    alu_remu   = 5'b10_111
  } alu_op_t;

  localparam logic [1:0] alu_class_muldiv = 2'b10;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } br_op_t;

  typedef logic [2:0] lsu_op_t;

  typedef enum logic [1:0] {res_alu, res_mul, res_div} res_sel_t;

  typedef enum logic [1:0] {st_idle, st_div_busy, st_div_done} exu_state_t;

endpackage

`default_nettype wire

// ==== verilog/exu_alu.sv ====
/*
 * base integer ALU and branch condition compare.
 */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0] a,
  input  logic [`EXU_XLEN-1:0] b,
  input  exu_pkg::alu_op_t     alu_op,
  input  exu_pkg::br_op_t      br_op,
  input  logic [`EXU_XLEN-1:0] br_a,
  input  logic [`EXU_XLEN-1:0] br_b,
  output logic [`EXU_XLEN-1:0] res,
  output logic                 br_cond
);

  localparam int xlen = `EXU_XLEN;
  localparam int shamt_w = $clog2(xlen);

  logic [shamt_w-1:0] shamt;
  logic               lt_s;
  logic               lt_u;

  assign shamt = b[shamt_w-1:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (alu_op)
      exu_pkg::alu_add:  res = a + b;
      exu_pkg::alu_sub:  res = a - b;
      exu_pkg::alu_sll:  res = a << shamt;
      exu_pkg::alu_slt:  res = {{(xlen-1){1'b0}}, lt_s};
      exu_pkg::alu_sltu: res = {{(xlen-1){1'b0}}, lt_u};
      exu_pkg::alu_xor:  res = a ^ b;
      exu_pkg::alu_srl:  res = a >> shamt;
      exu_pkg::alu_sra:  res = $signed(a) >>> shamt;
      exu_pkg::alu_or:   res = a | b;
      exu_pkg::alu_and:  res = a & b;
      default:           res = '0;
    endcase
  end

  // compares use the register values, never the muxed operands.
  always_comb begin
    case (br_op)
      exu_pkg::br_beq:  br_cond = (br_a == br_b);
      exu_pkg::br_bne:  br_cond = (br_a != br_b);
      exu_pkg::br_blt:  br_cond = ($signed(br_a) < $signed(br_b));
      exu_pkg::br_bge:  br_cond = ($signed(br_a) >= $signed(br_b));
      exu_pkg::br_bltu: br_cond = (br_a < br_b);
      exu_pkg::br_bgeu: br_cond = (br_a >= br_b);
      default:          br_cond = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/exu_muldiv.sv ====
/*
 * combinational multiplier for the four multiply forms and an
 * iterative restoring divider with sign fix-up.
 */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exu_muldiv (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`EXU_XLEN-1:0] a,
  input  logic [`EXU_XLEN-1:0] b,
  input  exu_pkg::alu_op_t     alu_op,
  input  logic                 div_start,
  output logic [`EXU_XLEN-1:0] mul_res,
  output logic [`EXU_XLEN-1:0] div_res,
  output logic                 div_done
);

  localparam int xlen = `EXU_XLEN;
  localparam int cnt_w = $clog2(`EXU_DIV_STEPS + 1);

  logic              a_sgn;
  logic              b_sgn;
  logic [2*xlen-1:0] prod;

  // high-word forms pick operand signedness.
  always_comb begin
    a_sgn = 1'b0;
    b_sgn = 1'b0;
    if (alu_op == exu_pkg::alu_mulh) begin
      a_sgn = a[xlen-1];
      b_sgn = b[xlen-1];
    end else if (alu_op == exu_pkg::alu_mulhsu) begin
      a_sgn = a[xlen-1];
    end
  end

  assign prod    = {{xlen{a_sgn}}, a} * {{xlen{b_sgn}}, b};
  assign mul_res = (alu_op == exu_pkg::alu_mul) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];

  logic             busy;
  logic [cnt_w-1:0] cnt;
  logic [xlen-1:0]  rem_q;
  logic [xlen-1:0]  quo_q;
  logic [xlen-1:0]  dvs_q;
  logic             neg_q;
  logic             neg_r;
  logic             div_zero;
  logic             want_rem;
  logic             a_neg;
  logic             b_neg;
  logic [xlen+1:0]  trial;

  // div and rem are the signed forms, bit 0 low.
  assign a_neg = !alu_op[0] && a[xlen-1];
  assign b_neg = !alu_op[0] && b[xlen-1];

  assign trial = {1'b0, rem_q, quo_q[xlen-1]} - {2'b00, dvs_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (div_start) begin
      busy <= 1'b1;
      cnt  <= cnt_w'(`EXU_DIV_STEPS);
    end else if (busy) begin
      busy <= (cnt != cnt_w'(1));
      cnt  <= cnt - 1'b1;
    end
  end

  // dividend shifts out of quo_q while quotient bits shift in.
  always_ff @(posedge clk) begin
    if (div_start) begin
      quo_q    <= a_neg ? -a : a;
      dvs_q    <= b_neg ? -b : b;
      rem_q    <= '0;
      neg_q    <= a_neg ^ b_neg;
      neg_r    <= a_neg;
      div_zero <= (b == '0);
      want_rem <= alu_op[1];
    end else if (busy) begin
      if (!trial[xlen+1]) begin
        rem_q <= trial[xlen-1:0];
        quo_q <= {quo_q[xlen-2:0], 1'b1};
      end else begin
        rem_q <= {rem_q[xlen-2:0], quo_q[xlen-1]};
        quo_q <= {quo_q[xlen-2:0], 1'b0};
      end
    end
  end

  // last step happens on this edge.
  assign div_done = busy && (cnt == cnt_w'(1));

  // divide by zero keeps an all-ones quotient whatever the dividend sign.
  always_comb begin
    if (want_rem) begin
      div_res = neg_r ? -rem_q : rem_q;
    end else if (div_zero) begin
      div_res = '1;
    end else begin
      div_res = neg_q ? -quo_q : quo_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exu_credit_counter.sv ====
/*
 * free slot counter for the memory stage.
 */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exu_credit_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic spend,
  input  logic give,
  output logic credit_avail
);

  localparam int cred_w = `EXU_CRED_W;

  logic [cred_w-1:0] count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= cred_w'(`EXU_CREDITS);
    end else begin
      case ({spend, give})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign credit_avail = (count != '0);

endmodule

`default_nettype wire

// ==== verilog/exu_ctrl.sv ====
/*
 * issue acceptance, divide sequencing and result select.
 */
`timescale 1ns/1ps
`default_nettype none

module exu_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                issue_valid,
  input  exu_pkg::alu_op_t    alu_op,
  input  logic                credit_avail,
  input  logic                div_done,
  output logic                stall,
  output logic                issue_fire,
  output logic                div_start,
  output exu_pkg::res_sel_t   res_sel,
  output logic                m_load
);

  exu_pkg::exu_state_t state;
  exu_pkg::exu_state_t state_nxt;

  logic is_muldiv;
  logic is_mul;
  logic is_div;

  assign is_muldiv = (alu_op[4:3] == exu_pkg::alu_class_muldiv);
  assign is_mul    = is_muldiv && !alu_op[2];
  assign is_div    = is_muldiv && alu_op[2];

  assign stall      = (state != exu_pkg::st_idle) || !credit_avail;
  assign issue_fire = issue_valid && !stall;
  assign div_start  = issue_fire && is_div;

  always_comb begin
    state_nxt = state;
    case (state)
      exu_pkg::st_idle: begin
        if (div_start) begin
          state_nxt = exu_pkg::st_div_busy;
        end
      end
      exu_pkg::st_div_busy: begin
        if (div_done) begin
          state_nxt = exu_pkg::st_div_done;
        end
      end
      default: state_nxt = exu_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= exu_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // single-cycle ops load at acceptance, divides one cycle after done.
  assign m_load = (state == exu_pkg::st_idle && issue_fire && !is_div) ||
                  (state == exu_pkg::st_div_done);

  // res_div only outside idle, so the memory stage can freeze its copy.
  always_comb begin
    if (state != exu_pkg::st_idle) begin
      res_sel = exu_pkg::res_div;
    end else if (is_mul) begin
      res_sel = exu_pkg::res_mul;
    end else begin
      res_sel = exu_pkg::res_alu;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exu_mstage.sv ====
/*
 * result select, misprediction flag and memory-stage register.
 */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exu_mstage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 m_load,
  input  exu_pkg::res_sel_t    res_sel,
  input  logic [`EXU_XLEN-1:0] alu_res,
  input  logic [`EXU_XLEN-1:0] mul_res,
  input  logic [`EXU_XLEN-1:0] div_res,
  input  logic                 br_cond,
  input  logic                 br_e,
  input  logic                 br_ataken_e,
  input  logic                 comp_e,
  input  logic                 lsu_e,
  input  exu_pkg::lsu_op_t     lsu_op_e,
  input  logic [4:0]           rd_addr_e,
  input  logic                 rd_en_e,
  input  logic [`EXU_XLEN-1:0] rs2_data_e,
  input  logic [`EXU_XLEN-1:1] pc_e,
  output logic                 m_valid,
  output logic [`EXU_XLEN-1:0] alu_res_m,
  output logic [`EXU_XLEN-1:0] store_data_m,
  output logic [`EXU_XLEN-1:1] pc_m,
  output logic [4:0]           rd_addr_m,
  output logic                 rd_en_m,
  output logic                 lsu_m,
  output exu_pkg::lsu_op_t     lsu_op_m,
  output logic                 br_m,
  output logic                 br_ataken_m,
  output logic                 br_misp_m,
  output logic                 comp_m
);

  localparam int fld_w = 2 * `EXU_XLEN + 12;

  logic             use_hold;
  logic [fld_w-1:0] fld_e;
  logic [fld_w-1:0] fld_h;
  logic [fld_w-1:0] fld;

  assign fld_e = {br_e, br_ataken_e, comp_e, lsu_e, lsu_op_e, rd_addr_e, rd_en_e,
                  rs2_data_e, pc_e};

  // hold copy follows issue until a division leaves idle.
  assign use_hold = (res_sel == exu_pkg::res_div);

  always_ff @(posedge clk) begin
    if (!use_hold) begin
      fld_h <= fld_e;
    end
  end

  assign fld = use_hold ? fld_h : fld_e;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid   <= 1'b0;
      br_m      <= 1'b0;
      br_misp_m <= 1'b0;
      rd_en_m   <= 1'b0;
      lsu_m     <= 1'b0;
    end else begin
      m_valid   <= m_load;
      br_m      <= m_load && fld[fld_w-1];
      br_misp_m <= m_load && fld[fld_w-1] && (br_cond != fld[fld_w-2]);
      lsu_m     <= m_load && fld[fld_w-4];
      rd_en_m   <= m_load && fld[2*`EXU_XLEN-1];
    end
  end

  always_ff @(posedge clk) begin
    if (m_load) begin
      case (res_sel)
        exu_pkg::res_mul: alu_res_m <= mul_res;
        exu_pkg::res_div: alu_res_m <= div_res;
        default:          alu_res_m <= alu_res;
      endcase
      br_ataken_m  <= fld[fld_w-2];
      comp_m       <= fld[fld_w-3];
      lsu_op_m     <= fld[fld_w-5 -: 3];
      rd_addr_m    <= fld[fld_w-8 -: 5];
      store_data_m <= fld[`EXU_XLEN-1 +: `EXU_XLEN];
      pc_m         <= fld[`EXU_XLEN-2:0];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exu.sv ====
/*
 * execute stage top with operand muxes, ALU, multiply/divide,
 * credit counter, control FSM and memory-stage register.
 */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exu (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 issue_valid,
  input  logic [`EXU_XLEN-1:0] rs1_data_e,
  input  logic [`EXU_XLEN-1:0] rs2_data_e,
  input  logic [`EXU_XLEN-1:1] pc_e,
  input  logic [`EXU_XLEN-1:0] imm_e,
  input  logic                 use_imm_e,
  input  logic                 use_pc_e,
  input  exu_pkg::alu_op_t     alu_op_e,
  input  logic                 br_e,
  input  exu_pkg::br_op_t      br_op_e,
  input  logic                 br_ataken_e,
  input  logic                 comp_e,
  input  logic                 lsu_e,
  input  exu_pkg::lsu_op_t     lsu_op_e,
  input  logic [4:0]           rd_addr_e,
  input  logic                 rd_en_e,
  input  logic                 credit_return,
  output logic                 stall,
  output logic                 m_valid,
  output logic [`EXU_XLEN-1:0] alu_res_m,
  output logic [`EXU_XLEN-1:0] store_data_m,
  output logic [`EXU_XLEN-1:1] pc_m,
  output logic [4:0]           rd_addr_m,
  output logic                 rd_en_m,
  output logic                 lsu_m,
  output exu_pkg::lsu_op_t     lsu_op_m,
  output logic                 br_m,
  output logic                 br_ataken_m,
  output logic                 br_misp_m,
  output logic                 comp_m
);

  logic [`EXU_XLEN-1:0] opa;
  logic [`EXU_XLEN-1:0] opb;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] mul_res;
  logic [`EXU_XLEN-1:0] div_res;
  logic                 br_cond;
  logic                 div_start;
  logic                 div_done;
  logic                 issue_fire;
  logic                 credit_avail;
  logic                 m_load;
  exu_pkg::res_sel_t    res_sel;

  // pc has no bit 0 stored.
  assign opa = use_pc_e ? {pc_e, 1'b0} : rs1_data_e;
  assign opb = use_imm_e ? imm_e : rs2_data_e;

  exu_alu u_alu (
    .a      (opa),
    .b      (opb),
    .alu_op (alu_op_e),
    .br_op  (br_op_e),
    .br_a   (rs1_data_e),
    .br_b   (rs2_data_e),
    .res    (alu_res),
    .br_cond(br_cond)
  );

  exu_muldiv u_muldiv (
    .clk      (clk),
    .rst_n    (rst_n),
    .a        (rs1_data_e),
    .b        (rs2_data_e),
    .alu_op   (alu_op_e),
    .div_start(div_start),
    .mul_res  (mul_res),
    .div_res  (div_res),
    .div_done (div_done)
  );

  exu_credit_counter u_credit (
    .clk         (clk),
    .rst_n       (rst_n),
    .spend       (issue_fire),
    .give        (credit_return),
    .credit_avail(credit_avail)
  );

  exu_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .alu_op      (alu_op_e),
    .credit_avail(credit_avail),
    .div_done    (div_done),
    .stall       (stall),
    .issue_fire  (issue_fire),
    .div_start   (div_start),
    .res_sel     (res_sel),
    .m_load      (m_load)
  );

  exu_mstage u_mstage (
    .clk         (clk),
    .rst_n       (rst_n),
    .m_load      (m_load),
    .res_sel     (res_sel),
    .alu_res     (alu_res),
    .mul_res     (mul_res),
    .div_res     (div_res),
    .br_cond     (br_cond),
    .br_e        (br_e),
    .br_ataken_e (br_ataken_e),
    .comp_e      (comp_e),
    .lsu_e       (lsu_e),
    .lsu_op_e    (lsu_op_e),
    .rd_addr_e   (rd_addr_e),
    .rd_en_e     (rd_en_e),
    .rs2_data_e  (rs2_data_e),
    .pc_e        (pc_e),
    .m_valid     (m_valid),
    .alu_res_m   (alu_res_m),
    .store_data_m(store_data_m),
    .pc_m        (pc_m),
    .rd_addr_m   (rd_addr_m),
    .rd_en_m     (rd_en_m),
    .lsu_m       (lsu_m),
    .lsu_op_m    (lsu_op_m),
    .br_m        (br_m),
    .br_ataken_m (br_ataken_m),
    .br_misp_m   (br_misp_m),
    .comp_m      (comp_m)
  );

endmodule

`default_nettype wire

// ==== sim/exu_checker.sv ====
/*
 * concurrent assertions on the credit and stall protocol of the
 * execute stage, bound into exu.
 */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exu_checker (
  input logic clk,
  input logic rst_n,
  input logic issue_fire,
  input logic credit_return,
  input logic credit_avail,
  input logic div_start,
  input logic stall,
  input logic m_valid
);

  localparam int div_cycles = `EXU_DIV_STEPS + 1;

  int credits;
  int in_flight;
  int div_age;

  // shadow credit count and results still owed.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits   <= `EXU_CREDITS;
      in_flight <= 0;
      div_age   <= 0;
    end else begin
      credits   <= credits - int'(issue_fire) + int'(credit_return);
      in_flight <= in_flight + int'(issue_fire) - int'(m_valid);
      if (div_start) begin
        div_age <= 1;
      end else if (div_age != 0) begin
        div_age <= (div_age == div_cycles) ? 0 : div_age + 1;
      end
    end
  end

  a_fire_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    issue_fire |-> (credits > 0) && credit_avail)
    else $error("instruction accepted with no credit left");

  a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
    (credits >= 0) && (credits <= `EXU_CREDITS))
    else $error("credit count out of range: %0d", credits);

  a_result_owed: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid |-> (in_flight > 0) && (in_flight <= `EXU_CREDITS))
    else $error("result delivered without an accepted instruction");

  // stall through the whole divide.
  a_div_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (div_age != 0) |-> stall)
    else $error("stall dropped during division");

endmodule

bind exu exu_checker u_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .issue_fire   (issue_fire),
  .credit_return(credit_return),
  .credit_avail (credit_avail),
  .div_start    (div_start),
  .stall        (stall),
  .m_valid      (m_valid)
);

`default_nettype wire

// ==== sim/tb_exu.sv ====
/*
 * testbench for the execute stage: reads vectors, drives issue,
 * returns credits after random delays and checks every result.
 */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module tb_exu;

  localparam int max_vec = 64;
  localparam int div_latency = `EXU_DIV_STEPS + 2;

  logic                 clk;
  logic                 rst_n;
  logic                 issue_valid;
  logic [`EXU_XLEN-1:0] rs1_data_e;
  logic [`EXU_XLEN-1:0] rs2_data_e;
  logic [`EXU_XLEN-1:1] pc_e;
  logic [`EXU_XLEN-1:0] imm_e;
  logic                 use_imm_e;
  logic                 use_pc_e;
  exu_pkg::alu_op_t     alu_op_e;
  logic                 br_e;
  exu_pkg::br_op_t      br_op_e;
  logic                 br_ataken_e;
  logic                 comp_e;
  logic                 lsu_e;
  exu_pkg::lsu_op_t     lsu_op_e;
  logic [4:0]           rd_addr_e;
  logic                 rd_en_e;
  logic                 credit_return;
  logic                 stall;
  logic                 m_valid;
  logic [`EXU_XLEN-1:0] alu_res_m;
  logic [`EXU_XLEN-1:0] store_data_m;
  logic [`EXU_XLEN-1:1] pc_m;
  logic [4:0]           rd_addr_m;
  logic                 rd_en_m;
  logic                 lsu_m;
  exu_pkg::lsu_op_t     lsu_op_m;
  logic                 br_m;
  logic                 br_ataken_m;
  logic                 br_misp_m;
  logic                 comp_m;

  // one entry per vector line.
  logic [3:0]  v_class [max_vec];
  logic [4:0]  v_alu_op [max_vec];
  logic [2:0]  v_br_op [max_vec];
  logic [31:0] v_rs1 [max_vec];
  logic [31:0] v_rs2 [max_vec];
  logic [31:0] v_imm [max_vec];
  logic [31:0] v_pc [max_vec];
  logic        v_use_imm [max_vec];
  logic        v_use_pc [max_vec];
  logic        v_pred [max_vec];
  logic [31:0] v_res [max_vec];
  logic        v_misp [max_vec];

  int n_vec = 0;
  int seed = 32'h314833d5;
  int cyc = 0;
  int cyc_limit = 1000;
  int issue_idx = 0;
  int cur_idx = 0;
  int fire_count = 0;
  int result_count = 0;
  int div_fire_cyc = 0;
  bit div_inflight = 1'b0;
  bit withhold = 1'b1;
  bit started = 1'b0;
  bit fired = 1'b0;
  int exp_idx_q[$];
  int exp_cyc_q[$];
  int ret_due_q[$];

  exu u_exu (.*);

  always #20 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      abort_run("stopping at the first mismatch");
    end
  endtask

  function automatic logic [4:0] rd_addr_for(input int idx);
    return 5'(idx % 31 + 1);
  endfunction

  function automatic logic [2:0] lsu_op_for(input int idx);
    return 3'(idx % 8);
  endfunction

  task automatic load_vectors();
    int fd;
    int n;
    reg [8*256-1:0] line;
    logic [31:0] c, op, bo, r1, r2, im, p, ui, up, pr, rs, mp;
    fd = $fopen("sim/exu_input.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the vector file sim/exu_input.txt");
    end
    while (!$feof(fd)) begin
      line = '0;
      if ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                    c, op, bo, r1, r2, im, p, ui, up, pr, rs, mp);
        // comment and blank lines give fewer fields.
        if (n == 12 && n_vec < max_vec) begin
          v_class[n_vec]   = c[3:0];
          v_alu_op[n_vec]  = op[4:0];
          v_br_op[n_vec]   = bo[2:0];
          v_rs1[n_vec]     = r1;
          v_rs2[n_vec]     = r2;
          v_imm[n_vec]     = im;
          v_pc[n_vec]      = p;
          v_use_imm[n_vec] = ui[0];
          v_use_pc[n_vec]  = up[0];
          v_pred[n_vec]    = pr[0];
          v_res[n_vec]     = rs;
          v_misp[n_vec]    = mp[0];
          n_vec++;
        end
      end
    end
    $fclose(fd);
    if (n_vec == 0) begin
      abort_run("the vector file holds no vectors");
    end
  endtask

  task drive_vector(input int idx);
    issue_valid <= 1'b1;
    rs1_data_e  <= v_rs1[idx];
    rs2_data_e  <= v_rs2[idx];
    pc_e        <= v_pc[idx][31:1];
    imm_e       <= v_imm[idx];
    use_imm_e   <= v_use_imm[idx];
    use_pc_e    <= v_use_pc[idx];
    alu_op_e    <= exu_pkg::alu_op_t'(v_alu_op[idx]);
    br_e        <= (v_class[idx] == 4'd3);
    br_op_e     <= exu_pkg::br_op_t'(v_br_op[idx]);
    br_ataken_e <= v_pred[idx];
    comp_e      <= (idx % 2 == 1);
    lsu_e       <= (idx % 3 == 0);
    lsu_op_e    <= lsu_op_for(idx);
    rd_addr_e   <= rd_addr_for(idx);
    rd_en_e     <= (v_class[idx] != 4'd3);
  endtask

  task automatic check_result();
    int idx;
    int lat;
    string tag;
    if (exp_idx_q.size() == 0) begin
      abort_run("m_valid pulsed with no instruction outstanding");
    end
    idx = exp_idx_q.pop_front();
    lat = cyc - exp_cyc_q.pop_front();
    tag = $sformatf("vec%0d", idx);
    check({tag, " latency"}, (v_class[idx] == 4'd2) ? div_latency : 1, lat);
    check({tag, " result"}, v_res[idx], alu_res_m);
    check({tag, " br_m"}, 32'(v_class[idx] == 4'd3), 32'(br_m));
    check({tag, " br_misp_m"}, 32'(v_misp[idx]), 32'(br_misp_m));
    check({tag, " br_ataken_m"}, 32'(v_pred[idx]), 32'(br_ataken_m));
    check({tag, " rd_addr_m"}, 32'(rd_addr_for(idx)), 32'(rd_addr_m));
    check({tag, " rd_en_m"}, 32'(v_class[idx] != 4'd3), 32'(rd_en_m));
    check({tag, " lsu_m"}, 32'(idx % 3 == 0), 32'(lsu_m));
    check({tag, " lsu_op_m"}, 32'(lsu_op_for(idx)), 32'(lsu_op_m));
    check({tag, " comp_m"}, 32'(idx % 2 == 1), 32'(comp_m));
    check({tag, " store_data_m"}, v_rs2[idx], store_data_m);
    check({tag, " pc_m"}, {1'b0, v_pc[idx][31:1]}, {1'b0, pc_m});
    if (v_class[idx] == 4'd2) begin
      div_inflight = 1'b0;
    end
    result_count++;
  endtask

  // next vector once the current one was taken.
  always @(posedge clk) begin
    if (started && (fired || !issue_valid)) begin
      if (issue_idx < n_vec) begin
        cur_idx = issue_idx;
        issue_idx = issue_idx + 1;
        drive_vector(cur_idx);
      end else begin
        issue_valid <= 1'b0;
      end
    end
  end

  // at most one credit back per cycle.
  always @(posedge clk) begin
    credit_return <= 1'b0;
    if (!withhold && ret_due_q.size() > 0) begin
      if (ret_due_q[0] <= cyc) begin
        void'(ret_due_q.pop_front());
        credit_return <= 1'b1;
      end
    end
  end

  // outputs settle by the falling edge.
  always @(negedge clk) begin
    int delay;
    cyc = cyc + 1;
    if (cyc > cyc_limit) begin
      abort_run($sformatf("timeout after %0d cycles with %0d of %0d results",
                          cyc, result_count, n_vec));
    end
    if (div_inflight && cyc > div_fire_cyc && !m_valid) begin
      check($sformatf("vec%0d stall during divide", exp_idx_q[0]), 1, 32'(stall));
    end
    if (m_valid) begin
      check_result();
      delay = $random(seed) % 6;
      if (delay < 0) begin
        delay = -delay;
      end
      ret_due_q.push_back(cyc + delay);
    end
    fired = issue_valid && !stall;
    if (fired) begin
      exp_idx_q.push_back(cur_idx);
      exp_cyc_q.push_back(cyc);
      fire_count++;
      if (v_class[cur_idx] == 4'd2) begin
        div_inflight = 1'b1;
        div_fire_cyc = cyc;
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    issue_valid = 1'b0;
    rs1_data_e = '0;
    rs2_data_e = '0;
    pc_e = '0;
    imm_e = '0;
    use_imm_e = 1'b0;
    use_pc_e = 1'b0;
    alu_op_e = exu_pkg::alu_add;
    br_e = 1'b0;
    br_op_e = exu_pkg::br_beq;
    br_ataken_e = 1'b0;
    comp_e = 1'b0;
    lsu_e = 1'b0;
    lsu_op_e = '0;
    rd_addr_e = '0;
    rd_en_e = 1'b0;
    credit_return = 1'b0;
    load_vectors();
    cyc_limit = 40 * n_vec + 100;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    started <= 1'b1;
    // credits withheld, so issue must stop after the granted slots.
    wait (fire_count == `EXU_CREDITS);
    repeat (10) begin
      @(negedge clk);
      check("credit stall", 1, 32'(stall));
      check("credit limit", `EXU_CREDITS, fire_count);
    end
    withhold = 1'b0;
    wait (result_count == n_vec);
    repeat (8) @(negedge clk);
    if (exp_idx_q.size() == 0 && fire_count == n_vec) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run($sformatf("%0d instructions accepted for %0d vectors", fire_count, n_vec));
    end
  end

endmodule

`default_nettype wire

// ==== sim/exu_input.txt ====
// class(0 alu 1 mul 2 div 3 branch) alu_op br_op rs1 rs2 imm pc
// use_imm use_pc pred_taken expected_result expected_mispredict, all hex
0 00 0 00000005 00000007 00000000 00001000 0 0 0 0000000c 0
0 08 0 00000003 00000005 00000000 00001004 0 0 0 fffffffe 0
0 00 0 00000010 0000abcd fffffff0 00001008 1 0 0 00000000 0
0 00 0 00000000 00000000 00002000 00001000 1 1 0 00003000 0
0 01 0 00000001 00000024 00000000 00001010 0 0 0 00000010 0
0 02 0 ffffffff 00000001 00000000 00001014 0 0 0 00000001 0
0 03 0 ffffffff 00000001 00000000 00001018 0 0 0 00000000 0
0 02 0 fffffff0 00000000 00000005 0000101c 1 0 0 00000001 0
0 04 0 f0f0f0f0 ff00ff00 00000000 00001020 0 0 0 0ff00ff0 0
0 05 0 80000000 0000001f 00000000 00001024 0 0 0 00000001 0
0 0d 0 80000000 00000004 00000000 00001028 0 0 0 f8000000 0
0 06 0 12340000 00005678 00000000 0000102c 0 0 0 12345678 0
0 07 0 ff00ff00 0f0f0f0f 00000000 00001030 0 0 0 0f000f00 0
1 10 0 fffffffe 00000003 00000000 00001034 0 0 0 fffffffa 0
1 11 0 fffffffe 00000003 00000000 00001038 0 0 0 ffffffff 0
1 12 0 80000000 00000004 00000000 0000103c 0 0 0 fffffffe 0
1 13 0 80000000 00000004 00000000 00001040 0 0 0 00000002 0
2 14 0 fffffff9 00000002 00000000 00001044 0 0 0 fffffffd 0
2 15 0 fffffff9 00000002 00000000 00001048 0 0 0 7ffffffc 0
2 16 0 fffffff9 00000002 00000000 0000104c 0 0 0 ffffffff 0
2 17 0 fffffff9 00000002 00000000 00001050 0 0 0 00000001 0
2 14 0 00000064 00000000 00000000 00001054 0 0 0 ffffffff 0
2 16 0 ffffff9c 00000000 00000000 00001058 0 0 0 ffffff9c 0
2 15 0 00000064 00000000 00000000 0000105c 0 0 0 ffffffff 0
2 17 0 00000064 00000000 00000000 00001060 0 0 0 00000064 0
2 14 0 80000000 ffffffff 00000000 00001064 0 0 0 80000000 0
2 16 0 80000000 ffffffff 00000000 00001068 0 0 0 00000000 0
3 00 0 00000005 00000005 00000010 00000100 1 1 1 00000110 0
3 00 1 00000005 00000005 fffffff8 00000200 1 1 1 000001f8 1
3 00 4 ffffffff 00000001 00000020 00000300 1 1 0 00000320 1
3 00 5 ffffffff 00000001 00000004 00000400 1 1 0 00000404 0
3 00 6 ffffffff 00000001 00000008 00000500 1 1 1 00000508 1
3 00 7 ffffffff 00000001 0000000c 00000600 1 1 1 0000060c 0
0 00 0 7fffffff 00000001 00000000 0000106c 0 0 0 80000000 0

// ==== sim.f ====
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_muldiv.sv
verilog/exu_credit_counter.sv
verilog/exu_ctrl.sv
verilog/exu_mstage.sv
verilog/exu.sv
sim/exu_checker.sv
sim/tb_exu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the execute stage testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_exu -o tb_exu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_exu 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi
